// File: rtl/ex_op_pkg.sv
// Operation definitions shared by the execute stage RTL and its testbench; import with ex_op_pkg::*
package ex_op_pkg;

  ////////////////////
  // Widths
  ////////////////////

  // Data path width
  localparam int XLEN  = 32;
  // Register file address width
  localparam int RF_AW = 5;
  // Opcode field width
  localparam int OP_W  = 5;

  ////////////////////
  // Opcodes
  ////////////////////

  // Codes 0 to 15 are defined, everything above is illegal
  typedef enum logic [OP_W-1:0] {
    // Single-cycle ALU ops
    OP_ADD   = 5'd0,
    OP_SUB   = 5'd1,
    OP_AND   = 5'd2,
    OP_OR    = 5'd3,
    OP_XOR   = 5'd4,
    OP_SLL   = 5'd5,
    OP_SRL   = 5'd6,
    OP_SRA   = 5'd7,
    OP_SLT   = 5'd8,
    OP_SLTU  = 5'd9,
    // Branch compares, evaluated by the ALU
    OP_BEQ   = 5'd10,
    OP_BNE   = 5'd11,
    OP_BLT   = 5'd12,
    OP_BGEU  = 5'd13,
    // Unsigned multiply, low and high word
    OP_MUL   = 5'd14,
    OP_MULHU = 5'd15
  } ex_op_e;

endpackage

// File: rtl/ex_pipe_pkg.sv
// Pipeline control types for the execute stage; imported by decode, multiplier, EX/WB register, top
package ex_pipe_pkg;

  // Functional unit selected by decode
  typedef enum logic [1:0] {
    UNIT_ALU  = 2'd0,
    UNIT_MUL  = 2'd1,
    // Undefined opcode, no unit runs it
    UNIT_NONE = 2'd2
  } ex_unit_e;

  // Iterative multiplier FSM
  typedef enum logic [1:0] {
    MUL_IDLE = 2'd0,
    MUL_BUSY = 2'd1,
    MUL_DONE = 2'd2
  } mul_state_e;

  // Bits of operand b consumed per BUSY cycle
  localparam int MUL_STEP_W = 8;
  // Number of BUSY cycles for a full 32-bit operand
  localparam int MUL_STEPS  = 4;

endpackage

// File: rtl/ex_decode.sv
// Execute stage opcode classifier; maps an opcode to a unit and gates unit enables by kill/halt
`timescale 1ns/1ps

module ex_decode
  import ex_op_pkg::*;
  import ex_pipe_pkg::*;
(
  input  logic     instr_valid_i,
  input  ex_op_e   op_i,
  input  logic     rf_we_i,
  input  logic     kill_i,
  input  logic     halt_i,
  output ex_unit_e unit_o,
  output logic     alu_en_o,
  output logic     mul_en_o,
  output logic     branch_o,
  output logic     illegal_o,
  output logic     rf_we_o
);

  // Instruction valid with kill and halt factored in
  logic instr_valid;

  assign instr_valid = instr_valid_i && !kill_i && !halt_i;

  ////////////////////
  // Unit select
  ////////////////////

  always_comb begin
    unit_o   = UNIT_NONE;
    branch_o = 1'b0;
    case (op_i)
      OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
      OP_SLL, OP_SRL, OP_SRA, OP_SLT, OP_SLTU: begin
        unit_o = UNIT_ALU;
      end
      // Branches use the ALU comparator
      OP_BEQ, OP_BNE, OP_BLT, OP_BGEU: begin
        unit_o   = UNIT_ALU;
        branch_o = 1'b1;
      end
      OP_MUL, OP_MULHU: begin
        unit_o = UNIT_MUL;
      end
      // Codes 16 and up fall through as UNIT_NONE
      default: begin
        unit_o = UNIT_NONE;
      end
    endcase
  end

  // Illegal opcode is a classification only, the top qualifies it
  assign illegal_o = (unit_o == UNIT_NONE);

  // Gated enables, so a killed or halted multiply drops back to idle
  assign alu_en_o = (unit_o == UNIT_ALU) && instr_valid;
  assign mul_en_o = (unit_o == UNIT_MUL) && instr_valid;

  // No register write for illegal ops or branches
  assign rf_we_o = rf_we_i && !illegal_o && !branch_o;

endmodule

// File: rtl/ex_alu.sv
// Single-cycle execute ALU: add/sub, logic, shifts, set-less-than and branch compares
`timescale 1ns/1ps

module ex_alu
  import ex_op_pkg::*;
(
  input  ex_op_e            op_i,
  input  logic [XLEN-1:0]   operand_a_i,
  input  logic [XLEN-1:0]   operand_b_i,
  output logic [XLEN-1:0]   result_o,
  output logic              cmp_result_o
);

  // Shared adder and comparator results
  logic [XLEN-1:0] sum;
  logic [XLEN-1:0] diff;
  logic            is_equal;
  logic            lt_signed;
  logic            lt_unsigned;
  // Shift amount, low 5 bits of operand b
  logic [4:0]      shamt;

  assign sum         = operand_a_i + operand_b_i;
  assign diff        = operand_a_i - operand_b_i;
  assign is_equal    = (operand_a_i == operand_b_i);
  assign lt_signed   = ($signed(operand_a_i) < $signed(operand_b_i));
  assign lt_unsigned = (operand_a_i < operand_b_i);
  assign shamt       = operand_b_i[4:0];

  ////////////////////
  // Result
  ////////////////////

  always_comb begin
    case (op_i)
      OP_ADD:  result_o = sum;
      OP_SUB:  result_o = diff;
      OP_AND:  result_o = operand_a_i & operand_b_i;
      OP_OR:   result_o = operand_a_i | operand_b_i;
      OP_XOR:  result_o = operand_a_i ^ operand_b_i;
      OP_SLL:  result_o = operand_a_i << shamt;
      OP_SRL:  result_o = operand_a_i >> shamt;
      OP_SRA:  result_o = XLEN'($signed(operand_a_i) >>> shamt);
      OP_SLT:  result_o = {{(XLEN-1){1'b0}}, lt_signed};
      OP_SLTU: result_o = {{(XLEN-1){1'b0}}, lt_unsigned};
      // Branches and non-ALU ops, result is never written
      default: result_o = sum;
    endcase
  end

  ////////////////////
  // Compare
  ////////////////////

  // Feeds the branch decision, also mirrors SLT/SLTU
  always_comb begin
    case (op_i)
      OP_BEQ:  cmp_result_o = is_equal;
      OP_BNE:  cmp_result_o = !is_equal;
      OP_BLT:  cmp_result_o = lt_signed;
      OP_BGEU: cmp_result_o = !lt_unsigned;
      OP_SLT:  cmp_result_o = lt_signed;
      OP_SLTU: cmp_result_o = lt_unsigned;
      default: cmp_result_o = 1'b0;
    endcase
  end

endmodule

// File: rtl/ex_mult.sv
// Iterative unsigned 32x32 multiplier, 8 bits of operand b per cycle, valid/ready handshake to WB
`timescale 1ns/1ps

module ex_mult
  import ex_op_pkg::*;
  import ex_pipe_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic              valid_i,
  input  logic              high_i,
  input  logic [XLEN-1:0]   op_a_i,
  input  logic [XLEN-1:0]   op_b_i,
  input  logic              ready_i,
  output logic [XLEN-1:0]   result_o,
  output logic              valid_o,
  output logic              ready_o
);

  mul_state_e state_q;
  // Step counter within BUSY
  logic [$clog2(MUL_STEPS)-1:0] step_q;
  // Operand a, shifted left one step per cycle
  logic [2*XLEN-1:0] a_sh_q;
  // Operand b, shifted right one step per cycle
  logic [XLEN-1:0]   b_sh_q;
  logic [2*XLEN-1:0] acc_q;
  logic [2*XLEN-1:0] partial;

  // Current 8-bit slice of b times the aligned a
  assign partial = a_sh_q * {{(2*XLEN-MUL_STEP_W){1'b0}}, b_sh_q[MUL_STEP_W-1:0]};

  ////////////////////
  // Control FSM
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= MUL_IDLE;
      step_q  <= '0;
    end else if (!valid_i) begin
      // Kill or halt, restart from scratch
      state_q <= MUL_IDLE;
      step_q  <= '0;
    end else begin
      case (state_q)
        MUL_IDLE: begin
          state_q <= MUL_BUSY;
          step_q  <= '0;
        end
        MUL_BUSY: begin
          step_q <= step_q + 1'b1;
          if (step_q == ($clog2(MUL_STEPS))'(MUL_STEPS-1)) begin
            state_q <= MUL_DONE;
          end
        end
        MUL_DONE: begin
          // Held under back-pressure
          if (ready_i) begin
            state_q <= MUL_IDLE;
          end
        end
        default: state_q <= MUL_IDLE;
      endcase
    end
  end

  ////////////////////
  // Datapath
  ////////////////////

  always_ff @(posedge clk) begin
    if (state_q == MUL_IDLE) begin
      // Latch operands, clear the accumulator
      a_sh_q <= {{XLEN{1'b0}}, op_a_i};
      b_sh_q <= op_b_i;
      acc_q  <= '0;
    end else if (state_q == MUL_BUSY) begin
      acc_q  <= acc_q + partial;
      a_sh_q <= a_sh_q << MUL_STEP_W;
      b_sh_q <= b_sh_q >> MUL_STEP_W;
    end
  end

  // High or low word of the 64-bit product
  assign result_o = high_i ? acc_q[2*XLEN-1:XLEN] : acc_q[XLEN-1:0];
  assign valid_o  = (state_q == MUL_DONE);
  // Not ready while a multiply is in progress
  assign ready_o  = !valid_i || (state_q == MUL_DONE);

endmodule

// File: rtl/ex_wb_reg.sv
// EX/WB pipeline register with result write mux, taken qualification and bubble insertion
`timescale 1ns/1ps

module ex_wb_reg
  import ex_op_pkg::*;
  import ex_pipe_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  ex_unit_e          unit_i,
  input  logic [XLEN-1:0]   alu_result_i,
  input  logic [XLEN-1:0]   mul_result_i,
  input  logic              cmp_result_i,
  input  logic              branch_i,
  input  logic              illegal_i,
  input  logic              rf_we_i,
  input  logic [RF_AW-1:0]  rf_waddr_i,
  input  logic              ex_valid_i,
  input  logic              wb_ready_i,
  output logic              wb_valid_o,
  output logic              wb_rf_we_o,
  output logic [RF_AW-1:0]  wb_rf_waddr_o,
  output logic [XLEN-1:0]   wb_rf_wdata_o,
  output logic              wb_bch_taken_o,
  output logic              wb_illegal_o
);

  logic [XLEN-1:0] rf_wdata;
  logic            bch_taken;
  logic            load;

  // Write data by unit; illegal ops never write so ALU is fine there
  always_comb begin
    case (unit_i)
      UNIT_MUL: rf_wdata = mul_result_i;
      default:  rf_wdata = alu_result_i;
    endcase
  end

  // Taken only for a branch on the ALU
  assign bch_taken = branch_i && (unit_i == UNIT_ALU) && cmp_result_i;
  assign load      = ex_valid_i && wb_ready_i;

  ////////////////////
  // Control part
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_valid_o     <= 1'b0;
      wb_rf_we_o     <= 1'b0;
      wb_bch_taken_o <= 1'b0;
      wb_illegal_o   <= 1'b0;
    end else if (load) begin
      wb_valid_o     <= 1'b1;
      wb_rf_we_o     <= rf_we_i;
      wb_bch_taken_o <= bch_taken;
      wb_illegal_o   <= illegal_i;
    end else if (wb_ready_i) begin
      // WB took the last entry and nothing new is here, insert bubble
      wb_valid_o <= 1'b0;
      wb_rf_we_o <= 1'b0;
    end
  end

  // Payload, only updated on a real register write
  always_ff @(posedge clk) begin
    if (load && rf_we_i) begin
      wb_rf_waddr_o <= rf_waddr_i;
      wb_rf_wdata_o <= rf_wdata;
    end
  end

endmodule

// File: rtl/ex_stage.sv
// Execute stage top; connects decode, ALU, multiplier and EX/WB register, forms ex_ready/ex_valid
`timescale 1ns/1ps

module ex_stage
  import ex_op_pkg::*;
  import ex_pipe_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic              instr_valid_i,
  input  ex_op_e            op_i,
  input  logic [XLEN-1:0]   operand_a_i,
  input  logic [XLEN-1:0]   operand_b_i,
  input  logic              rf_we_i,
  input  logic [RF_AW-1:0]  rf_waddr_i,
  input  logic              kill_i,
  input  logic              halt_i,
  input  logic              wb_ready_i,
  output logic              ex_ready_o,
  output logic              ex_valid_o,
  output logic              branch_decision_o,
  output logic              wb_valid_o,
  output logic              wb_rf_we_o,
  output logic [RF_AW-1:0]  wb_rf_waddr_o,
  output logic [XLEN-1:0]   wb_rf_wdata_o,
  output logic              wb_bch_taken_o,
  output logic              wb_illegal_o
);

  ex_unit_e        unit;
  logic            alu_en;
  logic            mul_en;
  logic            branch;
  logic            illegal;
  logic            rf_we;
  logic            instr_valid;
  logic [XLEN-1:0] alu_result;
  logic            cmp_result;
  logic [XLEN-1:0] mul_result;
  logic            mul_valid;
  logic            mul_ready;

  assign instr_valid = instr_valid_i && !kill_i && !halt_i;

  ex_decode ex_decode_inst (
    .instr_valid_i (instr_valid_i),
    .op_i          (op_i),
    .rf_we_i       (rf_we_i),
    .kill_i        (kill_i),
    .halt_i        (halt_i),
    .unit_o        (unit),
    .alu_en_o      (alu_en),
    .mul_en_o      (mul_en),
    .branch_o      (branch),
    .illegal_o     (illegal),
    .rf_we_o       (rf_we)
  );

  ex_alu ex_alu_inst (
    .op_i         (op_i),
    .operand_a_i  (operand_a_i),
    .operand_b_i  (operand_b_i),
    .result_o     (alu_result),
    .cmp_result_o (cmp_result)
  );

  // Downstream ready of the multiplier is WB
  ex_mult ex_mult_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .valid_i  (mul_en),
    .high_i   (op_i == OP_MULHU),
    .op_a_i   (operand_a_i),
    .op_b_i   (operand_b_i),
    .ready_i  (wb_ready_i),
    .result_o (mul_result),
    .valid_o  (mul_valid),
    .ready_o  (mul_ready)
  );

  ex_wb_reg ex_wb_reg_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .unit_i         (unit),
    .alu_result_i   (alu_result),
    .mul_result_i   (mul_result),
    .cmp_result_i   (cmp_result),
    .branch_i       (branch),
    .illegal_i      (illegal),
    .rf_we_i        (rf_we),
    .rf_waddr_i     (rf_waddr_i),
    .ex_valid_i     (ex_valid_o),
    .wb_ready_i     (wb_ready_i),
    .wb_valid_o     (wb_valid_o),
    .wb_rf_we_o     (wb_rf_we_o),
    .wb_rf_waddr_o  (wb_rf_waddr_o),
    .wb_rf_wdata_o  (wb_rf_wdata_o),
    .wb_bch_taken_o (wb_bch_taken_o),
    .wb_illegal_o   (wb_illegal_o)
  );

  // Straight from the comparator
  assign branch_decision_o = cmp_result;

  // Kill always consumes, halt always blocks
  assign ex_ready_o = kill_i || (mul_ready && wb_ready_i && !halt_i);

  // ALU and illegal ops are valid at once, multiply waits for DONE
  assign ex_valid_o = alu_en || (mul_en && mul_valid) || (illegal && instr_valid);

endmodule

// File: test/ex_stage_tb.sv
// Random-stimulus testbench for the execute stage with a reference model; top module ex_stage_tb
`timescale 1ns/1ps

module ex_stage_tb
  import ex_op_pkg::*;
();

  localparam int          NUM_INSTR      = 400;
  // Worst case per instruction, with slack for reset and drain
  localparam int          TIMEOUT_CYCLES = NUM_INSTR * 12 + 100;
  localparam logic [31:0] SEED           = 32'h3ee1_4b7d;

  // Expected EX/WB register contents for one consumed instruction
  typedef struct packed {
    logic [OP_W-1:0]  op;
    logic             rf_we;
    logic [RF_AW-1:0] waddr;
    logic [XLEN-1:0]  wdata;
    logic             taken;
    logic             illegal;
  } wb_entry_t;

  logic             clk = 1'b0;
  logic             rst_n;
  logic             instr_valid_i;
  ex_op_e           op_i;
  logic [XLEN-1:0]  operand_a_i;
  logic [XLEN-1:0]  operand_b_i;
  logic             rf_we_i;
  logic [RF_AW-1:0] rf_waddr_i;
  logic             kill_i;
  logic             halt_i;
  logic             wb_ready_i;
  logic             ex_ready_o;
  logic             ex_valid_o;
  logic             branch_decision_o;
  logic             wb_valid_o;
  logic             wb_rf_we_o;
  logic [RF_AW-1:0] wb_rf_waddr_o;
  logic [XLEN-1:0]  wb_rf_wdata_o;
  logic             wb_bch_taken_o;
  logic             wb_illegal_o;

  logic [31:0]      lfsr = SEED;
  int               cycle_cnt = 0;
  int               consumed = 0;
  int               value_errors = 0;
  int               other_errors = 0;
  wb_entry_t        exp_q[$];

  always #5 clk = !clk;

  ex_stage ex_stage_inst (
    .clk               (clk),
    .rst_n             (rst_n),
    .instr_valid_i     (instr_valid_i),
    .op_i              (op_i),
    .operand_a_i       (operand_a_i),
    .operand_b_i       (operand_b_i),
    .rf_we_i           (rf_we_i),
    .rf_waddr_i        (rf_waddr_i),
    .kill_i            (kill_i),
    .halt_i            (halt_i),
    .wb_ready_i        (wb_ready_i),
    .ex_ready_o        (ex_ready_o),
    .ex_valid_o        (ex_valid_o),
    .branch_decision_o (branch_decision_o),
    .wb_valid_o        (wb_valid_o),
    .wb_rf_we_o        (wb_rf_we_o),
    .wb_rf_waddr_o     (wb_rf_waddr_o),
    .wb_rf_wdata_o     (wb_rf_wdata_o),
    .wb_bch_taken_o    (wb_bch_taken_o),
    .wb_illegal_o      (wb_illegal_o)
  );

  ////////////////////
  // Random source
  ////////////////////

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One LFSR step per bit taken
  task automatic take_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      val  = {val[30:0], lfsr[0]};
    end
  endtask

  ////////////////////
  // Reference model
  ////////////////////

  function automatic logic branch_rule(input logic [OP_W-1:0] op, input logic [XLEN-1:0] a,
                                       input logic [XLEN-1:0] b);
    case (op)
      OP_BEQ:  return a == b;
      OP_BNE:  return a != b;
      OP_BLT:  return $signed(a) < $signed(b);
      OP_BGEU: return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic [XLEN-1:0] result_rule(input logic [OP_W-1:0] op,
                                                  input logic [XLEN-1:0] a,
                                                  input logic [XLEN-1:0] b);
    logic signed [XLEN-1:0] sa;
    logic [2*XLEN-1:0]      prod;
    sa   = a;
    // Full unsigned product for both multiply words
    prod = {{XLEN{1'b0}}, a} * {{XLEN{1'b0}}, b};
    case (op)
      OP_ADD:   return a + b;
      OP_SUB:   return a - b;
      OP_AND:   return a & b;
      OP_OR:    return a | b;
      OP_XOR:   return a ^ b;
      OP_SLL:   return a << b[4:0];
      OP_SRL:   return a >> b[4:0];
      OP_SRA:   return sa >>> b[4:0];
      OP_SLT:   return {{(XLEN-1){1'b0}}, ($signed(a) < $signed(b))};
      OP_SLTU:  return {{(XLEN-1){1'b0}}, (a < b)};
      OP_MUL:   return prod[XLEN-1:0];
      OP_MULHU: return prod[2*XLEN-1:XLEN];
      default:  return '0;
    endcase
  endfunction

  function automatic wb_entry_t expected_entry();
    wb_entry_t e;
    logic      branch;
    branch    = op_i inside {OP_BEQ, OP_BNE, OP_BLT, OP_BGEU};
    e.op      = op_i;
    e.illegal = (op_i > 5'd15);
    // Branches and illegal codes never write the register file
    e.rf_we   = rf_we_i && !e.illegal && !branch;
    e.waddr   = rf_waddr_i;
    e.wdata   = result_rule(op_i, operand_a_i, operand_b_i);
    e.taken   = branch && branch_rule(op_i, operand_a_i, operand_b_i);
    return e;
  endfunction

  task automatic report_mismatch(input string name, input logic [XLEN-1:0] exp,
                                 input logic [XLEN-1:0] act);
    value_errors++;
    $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
  endtask

  ////////////////////
  // Stimulus
  ////////////////////

  // New instruction on the next edge, with about 1 in 16 illegal codes
  task automatic present_instr();
    logic [31:0] r;
    logic [31:0] a;
    logic [4:0]  code;
    take_bits(5, r);
    code = r[4:0];
    take_bits(3, r);
    if (code[4] && r[2:0] != 0) begin
      code[4] = 1'b0;
    end
    op_i <= ex_op_e'(code);
    take_bits(32, a);
    operand_a_i <= a;
    // Equal operands now and then so BEQ/BGEU see both outcomes
    take_bits(3, r);
    if (r[2:0] == 0) begin
      operand_b_i <= a;
    end else begin
      take_bits(32, r);
      operand_b_i <= r;
    end
    take_bits(1, r);
    rf_we_i <= r[0];
    take_bits(RF_AW, r);
    rf_waddr_i <= r[RF_AW-1:0];
    instr_valid_i <= 1'b1;
  endtask

  // Hard limit on run length
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles with %0d of %0d instructions consumed",
               cycle_cnt, consumed, NUM_INSTR);
      $display("** FAIL **");
      $finish;
    end
  end

  initial begin
    logic [31:0] r;
    wb_entry_t   e;
    logic        exp_valid;
    rst_n         = 1'b0;
    instr_valid_i = 1'b0;
    op_i          = OP_ADD;
    operand_a_i   = '0;
    operand_b_i   = '0;
    rf_we_i       = 1'b0;
    rf_waddr_i    = '0;
    kill_i        = 1'b0;
    halt_i        = 1'b0;
    wb_ready_i    = 1'b0;
    repeat (2) @(posedge clk);
    if (wb_valid_o || wb_rf_we_o) begin
      other_errors++;
      $display("EX/WB register not empty after reset");
    end
    rst_n <= 1'b1;

    while (!(consumed == NUM_INSTR && exp_q.size() == 0)) begin
      @(posedge clk);
      // Branch decision is combinational on the presented operands
      if (instr_valid_i && ex_valid_o && (op_i inside {OP_BEQ, OP_BNE, OP_BLT, OP_BGEU})) begin
        if (branch_decision_o !== branch_rule(op_i, operand_a_i, operand_b_i)) begin
          report_mismatch("branch_decision", branch_rule(op_i, operand_a_i, operand_b_i),
                          branch_decision_o);
        end
      end
      if (halt_i && !kill_i && ex_ready_o) begin
        other_errors++;
        $display("ex_ready_o was high while halt_i was set");
      end
      // Valid only for a live instruction
      exp_valid = instr_valid_i && !kill_i && !halt_i;
      if (ex_valid_o && !exp_valid) begin
        other_errors++;
        $display("ex_valid_o was high without a live instruction");
      end
      // Single-cycle ops are valid at once and ready with WB
      if (instr_valid_i && !(op_i inside {OP_MUL, OP_MULHU})) begin
        if (ex_valid_o !== exp_valid) begin
          report_mismatch($sformatf("ex_valid op=%0d", op_i), exp_valid, ex_valid_o);
        end
        if (ex_ready_o !== (kill_i || (wb_ready_i && !halt_i))) begin
          report_mismatch($sformatf("ex_ready op=%0d", op_i),
                          kill_i || (wb_ready_i && !halt_i), ex_ready_o);
        end
      end
      // Writeback side first, it holds the older entry
      if (wb_ready_i && wb_valid_o) begin
        if (exp_q.size() == 0) begin
          other_errors++;
          $display("Writeback entry seen with no instruction outstanding");
        end else begin
          e = exp_q.pop_front();
          if (wb_rf_we_o !== e.rf_we) begin
            report_mismatch($sformatf("rf_we op=%0d", e.op), e.rf_we, wb_rf_we_o);
          end
          if (wb_illegal_o !== e.illegal) begin
            report_mismatch($sformatf("illegal op=%0d", e.op), e.illegal, wb_illegal_o);
          end
          if (wb_bch_taken_o !== e.taken) begin
            report_mismatch($sformatf("bch_taken op=%0d", e.op), e.taken, wb_bch_taken_o);
          end
          if (e.rf_we && wb_rf_wdata_o !== e.wdata) begin
            report_mismatch($sformatf("wdata op=%0d", e.op), e.wdata, wb_rf_wdata_o);
          end
          if (e.rf_we && wb_rf_waddr_o !== e.waddr) begin
            report_mismatch($sformatf("waddr op=%0d", e.op), e.waddr, wb_rf_waddr_o);
          end
        end
      end
      // Consumed this edge, killed ones leave no entry
      if (ex_ready_o && instr_valid_i) begin
        consumed++;
        if (!kill_i) begin
          exp_q.push_back(expected_entry());
        end
      end
      take_bits(4, r);
      kill_i <= (r[3:0] == 0);
      take_bits(4, r);
      halt_i <= (r[3:0] == 0);
      take_bits(2, r);
      wb_ready_i <= (r[1:0] != 0);
      // Hold the instruction until it is consumed
      if (!instr_valid_i || ex_ready_o) begin
        take_bits(2, r);
        if (consumed < NUM_INSTR && r[1:0] != 0) begin
          present_instr();
        end else begin
          instr_valid_i <= 1'b0;
        end
      end
    end

    // Idle cycles with WB ready must only give bubbles
    kill_i     <= 1'b0;
    halt_i     <= 1'b0;
    wb_ready_i <= 1'b1;
    repeat (4) begin
      @(posedge clk);
      if (wb_valid_o) begin
        other_errors++;
        $display("wb_valid_o high with no instruction outstanding");
      end
    end

    $display("Instructions: %0d, value errors: %0d, other errors: %0d",
             consumed, value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// File: src.f
rtl/ex_op_pkg.sv
rtl/ex_pipe_pkg.sv
rtl/ex_decode.sv
rtl/ex_alu.sv
rtl/ex_mult.sv
rtl/ex_wb_reg.sv
rtl/ex_stage.sv
test/ex_stage_tb.sv
